// File: logic/rvv_dispatch_pkg.sv
// ================================================
// shared sizes and vector types for the dispatch stage
// one 32-bit word per vector register, 8-entry ROB
// ================================================
package rvv_dispatch_pkg;

    localparam int ROB_DEPTH  = 8;
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);  // 3
    localparam int VREG_NUM   = 32;
    localparam int VREG_IDX_W = $clog2(VREG_NUM);   // 5
    localparam int DATA_W     = 32;

    typedef logic [VREG_IDX_W-1:0] vreg_idx_t;      // architectural vreg index
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;       // ROB pointer
    typedef logic [DATA_W-1:0]     vdata_t;         // one register word
    typedef logic [ROB_DEPTH-1:0]  rob_vec_t;       // one bit per ROB entry

    // destination tag kept in each ROB entry
    // msb set means no destination, so the tag never equals a source index
    typedef logic [VREG_IDX_W:0]   rob_dest_t;

    localparam vreg_idx_t V0_INDEX = '0;            // mask register

endpackage

// File: logic/raw_uop_rob.sv
// ================================================
// RAW check of one uop against every ROB entry
// conservative: any unwritten matching entry waits
// ================================================
module raw_uop_rob (
    input  rvv_dispatch_pkg::vreg_idx_t suc_vs1_index,
    input  rvv_dispatch_pkg::vreg_idx_t suc_vs2_index,
    input  rvv_dispatch_pkg::vreg_idx_t suc_vd_index,
    input  logic                        suc_vs1_valid,
    input  logic                        suc_vs2_valid,
    input  logic                        suc_vs3_valid,
    input  logic                        suc_vm,
    input  rvv_dispatch_pkg::rob_vec_t  ent_valid,
    input  rvv_dispatch_pkg::rob_vec_t  ent_w_valid,
    input  rvv_dispatch_pkg::rob_dest_t [rvv_dispatch_pkg::ROB_DEPTH-1:0] ent_w_index,
    output rvv_dispatch_pkg::rob_vec_t  vs1_hit,
    output rvv_dispatch_pkg::rob_vec_t  vs2_hit,
    output rvv_dispatch_pkg::rob_vec_t  vd_hit,
    output rvv_dispatch_pkg::rob_vec_t  v0_hit,
    output logic                        vs1_wait,
    output logic                        vs2_wait,
    output logic                        vd_wait,
    output logic                        v0_wait
);
    import rvv_dispatch_pkg::*;

    rob_vec_t vs1_cmp, vs2_cmp, vd_cmp, v0_cmp;     // index equality per entry
    rob_vec_t vs1_pend, vs2_pend, vd_pend, v0_pend; // hit on an unwritten entry

    genvar i;
    generate
        for (i = 0; i < ROB_DEPTH; i++) begin : gen_entry
            // zero-extended source vs tag, no-dest tags never match
            assign vs1_cmp[i] = ({1'b0, suc_vs1_index} == ent_w_index[i]);
            assign vs2_cmp[i] = ({1'b0, suc_vs2_index} == ent_w_index[i]);
            assign vd_cmp[i]  = ({1'b0, suc_vd_index}  == ent_w_index[i]);
            assign v0_cmp[i]  = ({1'b0, V0_INDEX}      == ent_w_index[i]);

            // hit = equal & source needed & entry live
            assign vs1_hit[i] = vs1_cmp[i] & suc_vs1_valid & ent_valid[i];
            assign vs2_hit[i] = vs2_cmp[i] & suc_vs2_valid & ent_valid[i];
            assign vd_hit[i]  = vd_cmp[i]  & suc_vs3_valid & ent_valid[i];
            assign v0_hit[i]  = v0_cmp[i]  & ~suc_vm       & ent_valid[i]; // masked op reads v0

            assign vs1_pend[i] = vs1_hit[i] & ~ent_w_valid[i];
            assign vs2_pend[i] = vs2_hit[i] & ~ent_w_valid[i];
            assign vd_pend[i]  = vd_hit[i]  & ~ent_w_valid[i];
            assign v0_pend[i]  = v0_hit[i]  & ~ent_w_valid[i];
        end
    endgenerate

    // any pending writer blocks that source
    assign vs1_wait = |vs1_pend;
    assign vs2_wait = |vs2_pend;
    assign vd_wait  = |vd_pend;
    assign v0_wait  = |v0_pend;

endmodule

// File: logic/rob_queue.sv
// ================================================
// circular ROB: alloc at tail, write-back by index,
// in-order retire from head, one per cycle
// caller must not alloc when full
// ================================================
module rob_queue (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        alloc_valid,
    input  rvv_dispatch_pkg::vreg_idx_t alloc_w_index,
    input  logic                        alloc_has_dest,
    input  logic                        wb_valid,
    input  rvv_dispatch_pkg::rob_idx_t  wb_rob_index,
    input  rvv_dispatch_pkg::vdata_t    wb_data,
    output logic                        full,
    output rvv_dispatch_pkg::rob_idx_t  tail_ptr,
    output rvv_dispatch_pkg::rob_idx_t  head_ptr,
    output rvv_dispatch_pkg::rob_vec_t  ent_valid,
    output rvv_dispatch_pkg::rob_vec_t  ent_w_valid,
    output rvv_dispatch_pkg::rob_dest_t [rvv_dispatch_pkg::ROB_DEPTH-1:0] ent_w_index,
    output rvv_dispatch_pkg::vdata_t    [rvv_dispatch_pkg::ROB_DEPTH-1:0] ent_data,
    output logic                        retire_valid,
    output rvv_dispatch_pkg::vreg_idx_t retire_index,
    output rvv_dispatch_pkg::vdata_t    retire_data
);
    import rvv_dispatch_pkg::*;

    logic [ROB_IDX_W:0] count;      // live entries, 0..ROB_DEPTH
    logic               empty;
    logic               retire_fire; // head leaves this cycle
    rob_dest_t          head_tag;

    assign full  = (count == (ROB_IDX_W+1)'(ROB_DEPTH));
    assign empty = (count == '0);

    // head pops once written back, no-dest entries come in already written
    assign retire_fire = ~empty & ent_valid[head_ptr] & ent_w_valid[head_ptr];
    assign head_tag    = ent_w_index[head_ptr];

    // register file write only when the head carries a destination
    assign retire_valid = retire_fire & ~head_tag[VREG_IDX_W];
    assign retire_index = head_tag[VREG_IDX_W-1:0];
    assign retire_data  = ent_data[head_ptr];

    // control state: pointers, count, per-entry flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr    <= '0;
            tail_ptr    <= '0;
            count       <= '0;
            ent_valid   <= '0;
            ent_w_valid <= '0;
        end else begin
            if (alloc_valid) begin
                ent_valid[tail_ptr]   <= 1'b1;
                ent_w_valid[tail_ptr] <= ~alloc_has_dest; // nothing to wait for
                tail_ptr              <= tail_ptr + 1'b1;  // wraps at depth
            end
            if (wb_valid) begin
                ent_w_valid[wb_rob_index] <= 1'b1;
            end
            if (retire_fire) begin
                ent_valid[head_ptr] <= 1'b0;
                head_ptr            <= head_ptr + 1'b1;
            end
            // alloc and retire never touch the same slot, see full
            case ({alloc_valid, retire_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload, qualified by the flags above
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_w_index[tail_ptr] <= {~alloc_has_dest, alloc_w_index};
        end
        if (wb_valid) begin
            ent_data[wb_rob_index] <= wb_data;
        end
    end

endmodule

// File: logic/vreg_file.sv
// ================================================
// architectural vregs, one word each, zero on reset
// 4 async read ports, 1 write port
// ================================================
module vreg_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        we,
    input  rvv_dispatch_pkg::vreg_idx_t waddr,
    input  rvv_dispatch_pkg::vdata_t    wdata,
    input  rvv_dispatch_pkg::vreg_idx_t raddr1,
    input  rvv_dispatch_pkg::vreg_idx_t raddr2,
    input  rvv_dispatch_pkg::vreg_idx_t raddr3,
    input  rvv_dispatch_pkg::vreg_idx_t raddr4,
    output rvv_dispatch_pkg::vdata_t    rdata1,
    output rvv_dispatch_pkg::vdata_t    rdata2,
    output rvv_dispatch_pkg::vdata_t    rdata3,
    output rvv_dispatch_pkg::vdata_t    rdata4
);
    import rvv_dispatch_pkg::*;

    vdata_t regs [VREG_NUM];

    // retire writes land at the edge, visible next cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < VREG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, ROB forwarding covers the retire cycle
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];
    assign rdata4 = regs[raddr4];

endmodule

// File: logic/dispatch_issue.sv
// ================================================
// valid/ready uop accept, stall on RAW or ROB full
// issue strobe one cycle after accept, no back-pressure
// ================================================
module dispatch_issue (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        uop_valid,
    output logic                        uop_ready,
    input  rvv_dispatch_pkg::vreg_idx_t uop_vs1_index,
    input  rvv_dispatch_pkg::vreg_idx_t uop_vs2_index,
    input  rvv_dispatch_pkg::vreg_idx_t uop_vd_index,
    input  logic                        uop_has_dest,
    input  logic                        full,
    input  rvv_dispatch_pkg::rob_idx_t  tail_ptr,
    input  rvv_dispatch_pkg::rob_idx_t  head_ptr,
    input  rvv_dispatch_pkg::rob_vec_t  vs1_hit,
    input  rvv_dispatch_pkg::rob_vec_t  vs2_hit,
    input  rvv_dispatch_pkg::rob_vec_t  vd_hit,
    input  rvv_dispatch_pkg::rob_vec_t  v0_hit,
    input  logic                        vs1_wait,
    input  logic                        vs2_wait,
    input  logic                        vd_wait,
    input  logic                        v0_wait,
    input  rvv_dispatch_pkg::vdata_t    [rvv_dispatch_pkg::ROB_DEPTH-1:0] ent_data,
    input  rvv_dispatch_pkg::vdata_t    rf_rdata1,
    input  rvv_dispatch_pkg::vdata_t    rf_rdata2,
    input  rvv_dispatch_pkg::vdata_t    rf_rdata3,
    input  rvv_dispatch_pkg::vdata_t    rf_rdata4,
    output logic                        alloc_valid,
    output rvv_dispatch_pkg::vreg_idx_t alloc_w_index,
    output logic                        alloc_has_dest,
    output rvv_dispatch_pkg::vreg_idx_t rf_raddr1,
    output rvv_dispatch_pkg::vreg_idx_t rf_raddr2,
    output rvv_dispatch_pkg::vreg_idx_t rf_raddr3,
    output rvv_dispatch_pkg::vreg_idx_t rf_raddr4,
    output logic                        issue_valid,
    output rvv_dispatch_pkg::rob_idx_t  issue_rob_index,
    output rvv_dispatch_pkg::vreg_idx_t issue_vd_index,
    output logic                        issue_has_dest,
    output rvv_dispatch_pkg::vdata_t    issue_vs1_data,
    output rvv_dispatch_pkg::vdata_t    issue_vs2_data,
    output rvv_dispatch_pkg::vdata_t    issue_vs3_data,
    output rvv_dispatch_pkg::vdata_t    issue_v0_data
);
    import rvv_dispatch_pkg::*;

    logic accept;

    // youngest hit wins, walk from tail-1 back to head
    function automatic vdata_t pick_operand(rob_vec_t hit, vdata_t [ROB_DEPTH-1:0] data,
                                            rob_idx_t tail, rob_idx_t head, vdata_t rf_word);
        rob_idx_t idx;
        vdata_t   result;
        logic     live;
        result = rf_word;   // nothing in flight for this source
        live   = 1'b1;
        for (int k = 1; k <= ROB_DEPTH; k++) begin
            idx = tail - rob_idx_t'(k);
            if (live && hit[idx]) begin
                result = data[idx];
                live   = 1'b0;
            end
            if (idx == head) live = 1'b0; // oldest entry checked
        end
        return result;
    endfunction

    assign uop_ready = ~full & ~(vs1_wait | vs2_wait | vd_wait | v0_wait);
    assign accept    = uop_valid & uop_ready;

    // new entry goes to the current tail
    assign alloc_valid    = accept;
    assign alloc_w_index  = uop_vd_index;
    assign alloc_has_dest = uop_has_dest;

    assign rf_raddr1 = uop_vs1_index;
    assign rf_raddr2 = uop_vs2_index;
    assign rf_raddr3 = uop_vd_index;   // vs3 reads vd
    assign rf_raddr4 = V0_INDEX;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) issue_valid <= 1'b0;
        else         issue_valid <= accept;
    end

    // operands sampled in the accept cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_rob_index <= tail_ptr;
            issue_vd_index  <= uop_vd_index;
            issue_has_dest  <= uop_has_dest;
            issue_vs1_data  <= pick_operand(vs1_hit, ent_data, tail_ptr, head_ptr, rf_rdata1);
            issue_vs2_data  <= pick_operand(vs2_hit, ent_data, tail_ptr, head_ptr, rf_rdata2);
            issue_vs3_data  <= pick_operand(vd_hit, ent_data, tail_ptr, head_ptr, rf_rdata3);
            issue_v0_data   <= pick_operand(v0_hit, ent_data, tail_ptr, head_ptr, rf_rdata4);
        end
    end

endmodule

// File: logic/vector_dispatch_top.sv
// ================================================
// dispatch stage top, single uop per cycle
// wb_valid only for allocated, unwritten dest entries
// ================================================
module vector_dispatch_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        uop_valid,
    output logic                        uop_ready,
    input  rvv_dispatch_pkg::vreg_idx_t uop_vs1_index,
    input  rvv_dispatch_pkg::vreg_idx_t uop_vs2_index,
    input  rvv_dispatch_pkg::vreg_idx_t uop_vd_index,
    input  logic                        uop_vs1_valid,
    input  logic                        uop_vs2_valid,
    input  logic                        uop_vs3_valid,
    input  logic                        uop_vm,
    input  logic                        uop_has_dest,
    input  logic                        wb_valid,
    input  rvv_dispatch_pkg::rob_idx_t  wb_rob_index,
    input  rvv_dispatch_pkg::vdata_t    wb_data,
    output logic                        issue_valid,
    output rvv_dispatch_pkg::rob_idx_t  issue_rob_index,
    output rvv_dispatch_pkg::vreg_idx_t issue_vd_index,
    output logic                        issue_has_dest,
    output rvv_dispatch_pkg::vdata_t    issue_vs1_data,
    output rvv_dispatch_pkg::vdata_t    issue_vs2_data,
    output rvv_dispatch_pkg::vdata_t    issue_vs3_data,
    output rvv_dispatch_pkg::vdata_t    issue_v0_data
);
    import rvv_dispatch_pkg::*;

    // ROB state
    logic                        full;
    rob_idx_t                    tail_ptr, head_ptr;
    rob_vec_t                    ent_valid, ent_w_valid;
    rob_dest_t [ROB_DEPTH-1:0]   ent_w_index;
    vdata_t    [ROB_DEPTH-1:0]   ent_data;
    // hazard results
    rob_vec_t                    vs1_hit, vs2_hit, vd_hit, v0_hit;
    logic                        vs1_wait, vs2_wait, vd_wait, v0_wait;
    // alloc / retire / rf reads
    logic                        alloc_valid, alloc_has_dest, retire_valid;
    vreg_idx_t                   alloc_w_index, retire_index;
    vdata_t                      retire_data;
    vreg_idx_t                   rf_raddr1, rf_raddr2, rf_raddr3, rf_raddr4;
    vdata_t                      rf_rdata1, rf_rdata2, rf_rdata3, rf_rdata4;

    raw_uop_rob i_raw_uop_rob (
        .suc_vs1_index(uop_vs1_index), .suc_vs2_index(uop_vs2_index),
        .suc_vd_index(uop_vd_index), .suc_vs1_valid(uop_vs1_valid),
        .suc_vs2_valid(uop_vs2_valid), .suc_vs3_valid(uop_vs3_valid), .suc_vm(uop_vm),
        .ent_valid, .ent_w_valid, .ent_w_index,
        .vs1_hit, .vs2_hit, .vd_hit, .v0_hit, .vs1_wait, .vs2_wait, .vd_wait, .v0_wait
    );

    rob_queue i_rob_queue (
        .clk, .arst_n, .alloc_valid, .alloc_w_index, .alloc_has_dest,
        .wb_valid, .wb_rob_index, .wb_data, .full, .tail_ptr, .head_ptr,
        .ent_valid, .ent_w_valid, .ent_w_index, .ent_data,
        .retire_valid, .retire_index, .retire_data
    );

    vreg_file i_vreg_file (
        .clk, .arst_n, .we(retire_valid), .waddr(retire_index), .wdata(retire_data),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2), .raddr3(rf_raddr3), .raddr4(rf_raddr4),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2), .rdata3(rf_rdata3), .rdata4(rf_rdata4)
    );

    dispatch_issue i_dispatch_issue (
        .clk, .arst_n, .uop_valid, .uop_ready, .uop_vs1_index, .uop_vs2_index,
        .uop_vd_index, .uop_has_dest, .full, .tail_ptr, .head_ptr,
        .vs1_hit, .vs2_hit, .vd_hit, .v0_hit, .vs1_wait, .vs2_wait, .vd_wait, .v0_wait,
        .ent_data, .rf_rdata1, .rf_rdata2, .rf_rdata3, .rf_rdata4,
        .alloc_valid, .alloc_w_index, .alloc_has_dest,
        .rf_raddr1, .rf_raddr2, .rf_raddr3, .rf_raddr4,
        .issue_valid, .issue_rob_index, .issue_vd_index, .issue_has_dest,
        .issue_vs1_data, .issue_vs2_data, .issue_vs3_data, .issue_v0_data
    );

endmodule

// File: tests/tb_vector_dispatch.sv
// ================================================
// dispatch stage checked against a ROB model
// inputs driven on the falling edge
// responder writes back issued dests after 0..5 cycles
// ================================================
module tb_vector_dispatch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 400;   // cycles allowed per wait

    logic        clk = 1'b0, arst_n = 1'b0;
    logic        uop_valid = 1'b0, uop_vs1_valid = 1'b0, uop_vs2_valid = 1'b0;
    logic        uop_vs3_valid = 1'b0, uop_vm = 1'b1, uop_has_dest = 1'b0;
    logic [4:0]  uop_vs1_index = '0, uop_vs2_index = '0, uop_vd_index = '0;
    logic        wb_valid = 1'b0;
    logic [2:0]  wb_rob_index = '0;
    logic [31:0] wb_data = '0;
    logic        uop_ready, issue_valid, issue_has_dest;
    logic [2:0]  issue_rob_index;
    logic [4:0]  issue_vd_index;
    logic [31:0] issue_vs1_data, issue_vs2_data, issue_vs3_data, issue_v0_data;

    // model ROB and register file
    logic [4:0]  m_widx [8];
    logic        m_hd [8], m_done [8];
    logic [31:0] m_data [8], m_rf [32];
    int          m_head = 0, m_tail = 0, m_count = 0;

    logic [31:0] seed = 32'h434f_b72b, r;
    logic [4:0]  req_vs1 = '0, req_vs2 = '0, req_vd = '0;
    logic [2:0]  req_need = '0;     // {vs3, vs2, vs1}
    logic        req_valid = 1'b0, req_vm = 1'b1, req_hd = 1'b0, accepted, wb_enable = 1'b1;
    logic        dut_accept = 1'b0; // DUT handshake seen this cycle
    logic [2:0]  pending [$], held; // issued dest entries awaiting wb
    logic        exp_issue = 1'b0, exp_hd;
    logic [2:0]  exp_rob;
    logic [4:0]  exp_vd;
    logic [31:0] exp_d [4];         // v0, vs1, vs2, vs3
    int          wb_delay = 0, errors = 0, mark = 0, tests_ok = 0, tests_bad = 0, stalls = 0;

    vector_dispatch_top i_vector_dispatch_top (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        $display("tests failed");
        $finish;
    endtask

    task automatic finish_test(input string name);
        if (errors == mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", name, errors - mark);
        end
        mark = errors;
    endtask

    // youngest matching dest entry, else the register file
    task automatic lookup(input logic [4:0] idx, input logic need,
                          output logic pend, output logic [31:0] val);
        int   e;
        logic found;
        pend  = 1'b0;
        found = 1'b0;
        val   = m_rf[idx];
        for (int k = 1; k <= m_count; k++) begin
            e = (m_tail + 8 - k) % 8;
            if (need && m_hd[e] && m_widx[e] == idx) begin
                pend = pend | ~m_done[e];   // any unwritten writer stalls
                if (!found) val = m_data[e];
                found = 1'b1;
            end
        end
    endtask

    // one clock of issue checks, write-back, uop drive, ready check and model step
    task automatic cycle();
        logic        p1, p2, p3, p0, ready, ret;
        logic [31:0] d1, d2, d3, d0;
        int          pick;
        @(negedge clk);
        check("issue_valid", 32'(issue_valid), 32'(exp_issue));
        if (exp_issue && issue_valid) begin
            check("issue_rob_index", 32'(issue_rob_index), 32'(exp_rob));
            check("issue_vd_index", 32'(issue_vd_index), 32'(exp_vd));
            check("issue_has_dest", 32'(issue_has_dest), 32'(exp_hd));
            check("issue_vs1_data", issue_vs1_data, exp_d[1]);
            check("issue_vs2_data", issue_vs2_data, exp_d[2]);
            check("issue_vs3_data", issue_vs3_data, exp_d[3]);
            check("issue_v0_data", issue_v0_data, exp_d[0]);
            if (exp_hd) pending.push_back(exp_rob);
        end
        wb_valid = 1'b0;
        if (wb_delay > 0) begin
            wb_delay--;
        end else if (wb_enable && pending.size() > 0) begin
            pick         = int'(next_rand() % 32'(pending.size())); // random wb order
            wb_valid     = 1'b1;
            wb_rob_index = pending[pick];
            wb_data      = next_rand();
            pending.delete(pick);
            wb_delay     = int'(next_rand() % 6);
        end
        uop_valid     = req_valid;
        uop_vs1_index = req_vs1;
        uop_vs2_index = req_vs2;
        uop_vd_index  = req_vd;
        uop_vs1_valid = req_need[0];
        uop_vs2_valid = req_need[1];
        uop_vs3_valid = req_need[2];
        uop_vm        = req_vm;
        uop_has_dest  = req_hd;
        #1;
        lookup(req_vs1, req_need[0], p1, d1);
        lookup(req_vs2, req_need[1], p2, d2);
        lookup(req_vd, req_need[2], p3, d3);
        lookup(5'd0, ~req_vm, p0, d0);      // masked op reads v0
        ready = (m_count < 8) && !(p1 | p2 | p3 | p0);
        check("uop_ready", 32'(uop_ready), 32'(ready));
        dut_accept = uop_valid & uop_ready;
        if (uop_valid && !uop_ready) stalls++;  // DUT held the uop back
        accepted  = req_valid && ready;
        exp_issue = accepted;
        ret       = (m_count > 0) && m_done[m_head];    // head state before the edge
        if (accepted) begin
            exp_rob   = 3'(m_tail);
            exp_vd    = req_vd;
            exp_hd    = req_hd;
            exp_d     = '{d0, d1, d2, d3};
            req_valid = 1'b0;
        end
        if (ret) begin
            if (m_hd[m_head]) m_rf[m_widx[m_head]] = m_data[m_head];
            m_head = (m_head + 1) % 8;
            m_count--;
        end
        if (wb_valid) begin
            m_done[wb_rob_index] = 1'b1;
            m_data[wb_rob_index] = wb_data;
        end
        if (accepted) begin
            m_widx[m_tail] = req_vd;
            m_hd[m_tail]   = req_hd;
            m_done[m_tail] = ~req_hd;   // no dest means done on arrival
            m_tail         = (m_tail + 1) % 8;
            m_count++;
        end
    endtask

    task automatic send(input logic [4:0] vs1, vs2, vd, input logic [2:0] need,
                        input logic vm, hd);
        int waited;
        req_vs1   = vs1;
        req_vs2   = vs2;
        req_vd    = vd;
        req_need  = need;
        req_vm    = vm;
        req_hd    = hd;
        req_valid = 1'b1;
        waited    = 0;
        stalls    = 0;
        accepted  = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            cycle();
            waited++;
        end
        if (!accepted) abort("a uop was not accepted within the timeout");
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((m_count > 0 || exp_issue || pending.size() > 0) && n < TIMEOUT) begin
            cycle();
            n++;
        end
        if (m_count > 0 || pending.size() > 0) abort("the ROB did not drain within the timeout");
    endtask

    initial begin
        for (int i = 0; i < 32; i++) m_rf[i] = '0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        #1;
        check("uop_ready", 32'(uop_ready), 32'd1);
        check("issue_valid", 32'(issue_valid), 32'd0);
        finish_test("after reset");

        send(5'd1, 5'd2, 5'd3, 3'b111, 1'b0, 1'b1);
        drain();
        finish_test("register read without hazard");

        wb_enable = 1'b0;
        send(5'd0, 5'd0, 5'd9, 3'b000, 1'b1, 1'b1);    // older writer holds the head
        send(5'd0, 5'd0, 5'd6, 3'b000, 1'b1, 1'b1);
        cycle();
        held      = pending.pop_front();
        wb_enable = 1'b1;
        send(5'd6, 5'd6, 5'd6, 3'b111, 1'b1, 1'b0);    // v6 forwarded from the ROB
        pending.push_back(held);
        drain();
        finish_test("forwarding");

        send(5'd0, 5'd0, 5'd0, 3'b000, 1'b1, 1'b1);
        send(5'd0, 5'd0, 5'd0, 3'b000, 1'b0, 1'b0);    // needs only v0
        check("v0 stall", 32'(stalls > 0), 32'd1);
        send(5'd0, 5'd0, 5'd4, 3'b000, 1'b1, 1'b1);
        send(5'd0, 5'd0, 5'd4, 3'b100, 1'b1, 1'b0);    // vs3 read of v4
        check("vs3 stall", 32'(stalls > 0), 32'd1);
        drain();
        finish_test("RAW stall");

        wb_enable = 1'b0;
        for (int i = 0; i < 8; i++) send(5'(i + 8), 5'd0, 5'(i + 8), 3'b000, 1'b1, 1'b1);
        req_valid = 1'b1;   // ninth uop sees a full ROB
        repeat (3) begin
            cycle();
            check("accept while full", 32'(dut_accept), 32'd0);
        end
        wb_enable = 1'b1;
        send(5'd15, 5'd0, 5'd15, 3'b000, 1'b1, 1'b1);  // same uop held while stalled
        drain();
        finish_test("ROB full");

        for (int u = 0; u < 2000; u++) begin
            r = next_rand();
            // indexes 0..3 keep hazards and v0 writes frequent
            send(5'(r[1:0]), 5'(r[3:2]), 5'(r[5:4]), r[8:6], r[9], r[12:10] != 3'd0);
        end
        drain();
        finish_test("random run");

        $display("tests: %0d ok, %0d with mismatches, %0d mismatches", tests_ok, tests_bad,
                 errors);
        if (errors == 0) $display("all tests passed");
        else $display("tests failed");
        $finish;
    end

endmodule

// File: all.f
logic/rvv_dispatch_pkg.sv
logic/raw_uop_rob.sv
logic/rob_queue.sv
logic/vreg_file.sv
logic/dispatch_issue.sv
logic/vector_dispatch_top.sv
tests/tb_vector_dispatch.sv

// File: build.sh
#!/bin/sh
# compile and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_vector_dispatch -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
out=$(./obj_dir/Vtb_vector_dispatch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
